// File: rtl/sar_pkg.sv
package sar_pkg;

    // Coalesce record index
    typedef logic [3:0] frag_ptr_t;

    // Reassembly buffer id
    typedef logic [5:0] buf_id_t;

    // Byte offset within a frame
    typedef logic [13:0] offset_t;

    // One record per pointer value
    localparam int NUM_FRAGS = 2 ** $bits(frag_ptr_t);

    // Frame context reported with done events
    typedef struct packed {
        buf_id_t buf_id;
        offset_t offset_start;
        offset_t offset_end;
    } frame_ctxt_t;

endpackage : sar_pkg

// File: rtl/state_pkg.sv
package state_pkg;

    // Millisecond stamp, wraps
    typedef logic [7:0] timer_t;

    // Who is writing a record
    typedef enum logic {
        UPDATE_CTXT_DATAPATH,
        UPDATE_CTXT_REAP
    } update_ctxt_t;

    typedef enum logic {
        NOTIFY_DONE,
        NOTIFY_EXPIRED
    } notify_kind_t;

    // Stored fragment record
    typedef struct packed {
        logic             valid;
        sar_pkg::buf_id_t buf_id;
        sar_pkg::offset_t offset_start;
        sar_pkg::offset_t offset_end;
        timer_t           timer;
        logic             last;
        logic             notified;
    } frag_state_t;

endpackage : state_pkg

// File: rtl/state_update_intf.sv
`timescale 1ns/1ps

interface state_update_intf;

    logic                    req;
    state_pkg::update_ctxt_t ctxt;
    sar_pkg::frag_ptr_t      id;
    state_pkg::frag_state_t  update;
    logic                    rdy;
    logic                    ack;

    modport requester (
        output req, ctxt, id, update,
        input  rdy, ack
    );

    modport store (
        input  req, ctxt, id, update,
        output rdy, ack
    );

endinterface : state_update_intf

// File: rtl/state_event_intf.sv
`timescale 1ns/1ps

interface state_event_intf;

    logic                    evt;
    sar_pkg::frag_ptr_t      id;
    state_pkg::notify_kind_t kind;
    sar_pkg::frame_ctxt_t    ctxt;

    modport source (output evt, id, kind, ctxt);

    modport sink (input evt, id, kind, ctxt);

    // Observes events raised by another block
    modport monitor (input evt, id, kind, ctxt);

endinterface : state_event_intf

// File: rtl/fifo_small.sv
`timescale 1ns/1ps

module fifo_small #(
    parameter type DATA_T = logic,
    parameter int  DEPTH  = 8
) (
    input  logic  clk,
    input  logic  srst,
    input  logic  wr,
    input  DATA_T wr_data,
    output logic  full,
    input  logic  rd,
    output DATA_T rd_data,
    output logic  empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    DATA_T            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = wr && !full;
    assign rd_en = rd && !empty;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Head entry always visible
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : fifo_small

// File: rtl/frag_state_store.sv
`timescale 1ns/1ps

module frag_state_store (
    input  logic                   clk,
    input  logic                   srst,
    output logic                   init_done,
    state_update_intf.store        upd_if,
    state_update_intf.store        reap_if,
    state_event_intf.source        done_evt_if,
    state_event_intf.monitor       expired_evt_if,
    input  logic                   scan_rd,
    input  sar_pkg::frag_ptr_t     scan_addr,
    output state_pkg::frag_state_t scan_data
);

    localparam int PTR_W = $bits(sar_pkg::frag_ptr_t);

    state_pkg::frag_state_t state_mem [sar_pkg::NUM_FRAGS];
    state_pkg::frag_state_t upd_cur;
    state_pkg::frag_state_t upd_rec;
    logic [PTR_W:0]         init_cnt;
    logic                   upd_acc;
    logic                   reap_acc;
    logic                   mark_expired;

    // --------------------
    // Clear sweep after reset
    // --------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            if (init_cnt == (PTR_W + 1)'(sar_pkg::NUM_FRAGS)) begin
                init_done <= 1'b1;
            end else begin
                init_cnt <= init_cnt + 1'b1;
            end
        end
    end

    // Datapath always wins the single write port
    assign upd_if.rdy  = 1'b1;
    assign reap_if.rdy = init_done && !upd_if.req;

    assign upd_acc  = upd_if.req && upd_if.rdy;
    assign reap_acc = reap_if.req && reap_if.rdy;

    // Update valid low means a later fragment, so the first stamp is kept
    assign upd_cur = state_mem[upd_if.id];
    always_comb begin
        upd_rec       = upd_if.update;
        upd_rec.valid = 1'b1;
        if (!upd_if.update.valid && upd_cur.valid) begin
            upd_rec.timer = upd_cur.timer;
        end
    end

    // Skip marks for a record that was replaced since the scan read it
    assign mark_expired = expired_evt_if.evt &&
                          (expired_evt_if.kind == state_pkg::NOTIFY_EXPIRED) &&
                          state_mem[expired_evt_if.id].valid &&
                          (state_mem[expired_evt_if.id].buf_id == expired_evt_if.ctxt.buf_id);

    // --------------------
    // Record array
    // --------------------
    always_ff @(posedge clk) begin
        if (!init_done) begin
            if (init_cnt < (PTR_W + 1)'(sar_pkg::NUM_FRAGS)) begin
                state_mem[init_cnt[PTR_W-1:0]] <= '0;
            end
        end else begin
            if (mark_expired) begin
                state_mem[expired_evt_if.id].notified <= 1'b1;
            end
            if (upd_acc) begin
                state_mem[upd_if.id] <=
                    (upd_if.ctxt == state_pkg::UPDATE_CTXT_REAP) ? '0 : upd_rec;
            end
            if (reap_acc) begin
                state_mem[reap_if.id] <=
                    (reap_if.ctxt == state_pkg::UPDATE_CTXT_REAP) ? '0 : reap_if.update;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            upd_if.ack      <= 1'b0;
            reap_if.ack     <= 1'b0;
            done_evt_if.evt <= 1'b0;
        end else begin
            upd_if.ack  <= upd_acc && (upd_if.ctxt == state_pkg::UPDATE_CTXT_REAP);
            reap_if.ack <= reap_acc && (reap_if.ctxt == state_pkg::UPDATE_CTXT_REAP);
            // Start at zero plus last flag closes the frame
            done_evt_if.evt <= upd_acc && (upd_if.ctxt == state_pkg::UPDATE_CTXT_DATAPATH) &&
                               upd_if.update.last && (upd_if.update.offset_start == '0);
        end
    end

    always_ff @(posedge clk) begin
        done_evt_if.id                <= upd_if.id;
        done_evt_if.ctxt.buf_id       <= upd_if.update.buf_id;
        done_evt_if.ctxt.offset_start <= upd_if.update.offset_start;
        done_evt_if.ctxt.offset_end   <= upd_if.update.offset_end;
    end

    assign done_evt_if.kind = state_pkg::NOTIFY_DONE;

    // Scan port reads as empty records until the sweep is over
    always_ff @(posedge clk) begin
        if (scan_rd) begin
            scan_data <= init_done ? state_mem[scan_addr] : '0;
        end
    end

endmodule : frag_state_store

// File: rtl/frag_expiry_scan.sv
`timescale 1ns/1ps

module frag_expiry_scan #(
    parameter int EXPIRE_MS   = 4,
    parameter int SCAN_PERIOD = 2
) (
    input  logic                   clk,
    input  logic                   srst,
    input  state_pkg::timer_t      timer,
    output logic                   scan_rd,
    output sar_pkg::frag_ptr_t     scan_addr,
    input  state_pkg::frag_state_t scan_data,
    state_event_intf.source        expired_evt_if
);

    localparam int CNT_W = (SCAN_PERIOD > 1) ? $clog2(SCAN_PERIOD) : 1;

    logic [CNT_W-1:0]   period_cnt;
    logic               rd_pending;
    sar_pkg::frag_ptr_t rd_addr;
    state_pkg::timer_t  age;
    logic               complete;

    // One read per period
    assign scan_rd = (period_cnt == CNT_W'(SCAN_PERIOD - 1));

    always_ff @(posedge clk) begin
        if (srst) begin
            period_cnt <= '0;
            scan_addr  <= '0;
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= scan_rd;
            if (scan_rd) begin
                period_cnt <= '0;
                scan_addr  <= scan_addr + 1'b1;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    // Address of the read in flight
    always_ff @(posedge clk) begin
        if (scan_rd) begin
            rd_addr <= scan_addr;
        end
    end

    // --------------------
    // Age check
    // --------------------
    assign age      = timer - scan_data.timer;
    // Complete frames are already queued for deletion
    assign complete = scan_data.last && (scan_data.offset_start == '0);

    assign expired_evt_if.evt  = rd_pending && scan_data.valid && !scan_data.notified &&
                                 !complete && (age >= EXPIRE_MS);
    assign expired_evt_if.id   = rd_addr;
    assign expired_evt_if.kind = state_pkg::NOTIFY_EXPIRED;
    assign expired_evt_if.ctxt = '{
        buf_id:       scan_data.buf_id,
        offset_start: scan_data.offset_start,
        offset_end:   scan_data.offset_end
    };

endmodule : frag_expiry_scan

// File: rtl/sar_reassembly_state.sv
`timescale 1ns/1ps

module sar_reassembly_state #(
    parameter int QUEUE_DEPTH = 8,
    parameter int EXPIRE_MS   = 4,
    parameter int SCAN_PERIOD = 2
) (
    input  logic               clk,
    input  logic               srst,
    input  logic               init_done,
    input  logic               frag_valid,
    input  logic               frag_init,
    input  sar_pkg::frag_ptr_t frag_ptr,
    input  sar_pkg::buf_id_t   frag_buf_id,
    input  sar_pkg::offset_t   frag_offset_start,
    input  sar_pkg::offset_t   frag_offset_end,
    input  logic               frag_last,
    input  logic               frag_merged,
    input  sar_pkg::frag_ptr_t frag_merged_ptr,
    input  logic               ms_tick,
    input  logic               frame_ready,
    output logic               frame_valid,
    output sar_pkg::buf_id_t   frame_buf_id,
    output sar_pkg::offset_t   frame_len,
    input  logic               frag_ptr_dealloc_rdy,
    output logic               frag_ptr_dealloc_req,
    output sar_pkg::frag_ptr_t frag_ptr_dealloc_value,
    state_update_intf.requester upd_if,
    state_update_intf.requester reap_if,
    state_event_intf.sink       done_evt_if,
    state_event_intf.sink       expired_evt_if,
    output state_pkg::timer_t  timer
);

    typedef struct packed {
        sar_pkg::frag_ptr_t   id;
        sar_pkg::frame_ctxt_t ctxt;
    } done_item_t;

    typedef enum logic [2:0] {
        IDLE,
        NOTIFY_DONE,
        DELETE_REQ,
        DELETE_PENDING,
        DEALLOC_PTR
    } fsm_state_t;

    fsm_state_t         fsm_state;
    fsm_state_t         nxt_fsm_state;
    sar_pkg::frag_ptr_t cur_ptr;

    logic               q_done_wr;
    done_item_t         q_done_wr_data;
    logic               q_done_rd;
    done_item_t         q_done_rd_data;
    logic               q_done_empty;
    logic               q_merged_rd;
    sar_pkg::frag_ptr_t q_merged_rd_data;
    logic               q_merged_empty;
    logic               q_expired_wr;
    logic               q_expired_rd;
    sar_pkg::frag_ptr_t q_expired_rd_data;
    logic               q_expired_empty;

    // --------------------
    // Millisecond timer
    // --------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            timer <= '0;
        end else if (ms_tick) begin
            timer <= timer + 1'b1;
        end
    end

    // Datapath writes, held off during the clear sweep
    assign upd_if.req  = frag_valid && init_done;
    assign upd_if.ctxt = state_pkg::UPDATE_CTXT_DATAPATH;
    assign upd_if.id   = frag_ptr;
    assign upd_if.update = '{
        valid:        frag_init,
        buf_id:       frag_buf_id,
        offset_start: frag_offset_start,
        offset_end:   frag_offset_end,
        timer:        timer,
        last:         frag_last,
        notified:     1'b0
    };

    // --------------------
    // Deletion queues
    // --------------------
    assign q_done_wr      = done_evt_if.evt && (done_evt_if.kind == state_pkg::NOTIFY_DONE);
    assign q_done_wr_data = '{id: done_evt_if.id, ctxt: done_evt_if.ctxt};
    assign q_expired_wr   = expired_evt_if.evt &&
                            (expired_evt_if.kind == state_pkg::NOTIFY_EXPIRED);

    fifo_small #(.DATA_T(done_item_t), .DEPTH(QUEUE_DEPTH)) i_fifo_small_done (
        .clk(clk), .srst(srst),
        .wr(q_done_wr), .wr_data(q_done_wr_data), .full(),
        .rd(q_done_rd), .rd_data(q_done_rd_data), .empty(q_done_empty)
    );

    fifo_small #(.DATA_T(sar_pkg::frag_ptr_t), .DEPTH(QUEUE_DEPTH)) i_fifo_small_merged (
        .clk(clk), .srst(srst),
        .wr(frag_merged), .wr_data(frag_merged_ptr), .full(),
        .rd(q_merged_rd), .rd_data(q_merged_rd_data), .empty(q_merged_empty)
    );

    fifo_small #(.DATA_T(sar_pkg::frag_ptr_t), .DEPTH(QUEUE_DEPTH)) i_fifo_small_expired (
        .clk(clk), .srst(srst),
        .wr(q_expired_wr), .wr_data(expired_evt_if.id), .full(),
        .rd(q_expired_rd), .rd_data(q_expired_rd_data), .empty(q_expired_empty)
    );

    // --------------------
    // Deletion FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            fsm_state <= IDLE;
        end else begin
            fsm_state <= nxt_fsm_state;
        end
    end

    always_comb begin
        nxt_fsm_state        = fsm_state;
        q_done_rd            = 1'b0;
        q_merged_rd          = 1'b0;
        q_expired_rd         = 1'b0;
        reap_if.req          = 1'b0;
        frame_valid          = 1'b0;
        frag_ptr_dealloc_req = 1'b0;
        case (fsm_state)
            IDLE: begin
                // Merged first, then done, then expired
                if (!q_merged_empty) begin
                    q_merged_rd   = 1'b1;
                    nxt_fsm_state = DELETE_REQ;
                end else if (!q_done_empty && frame_ready) begin
                    q_done_rd     = 1'b1;
                    nxt_fsm_state = NOTIFY_DONE;
                end else if (!q_expired_empty) begin
                    q_expired_rd  = 1'b1;
                    nxt_fsm_state = DELETE_REQ;
                end
            end
            NOTIFY_DONE: begin
                frame_valid = 1'b1;
                if (frame_ready) begin
                    nxt_fsm_state = DELETE_REQ;
                end
            end
            DELETE_REQ: begin
                reap_if.req = 1'b1;
                if (reap_if.rdy) begin
                    nxt_fsm_state = DELETE_PENDING;
                end
            end
            DELETE_PENDING: begin
                if (reap_if.ack) begin
                    nxt_fsm_state = DEALLOC_PTR;
                end
            end
            DEALLOC_PTR: begin
                frag_ptr_dealloc_req = 1'b1;
                if (frag_ptr_dealloc_rdy) begin
                    nxt_fsm_state = IDLE;
                end
            end
            default: nxt_fsm_state = IDLE;
        endcase
    end

    // Pointer and frame fields of the item in service
    always_ff @(posedge clk) begin
        if (q_merged_rd) begin
            cur_ptr <= q_merged_rd_data;
        end else if (q_done_rd) begin
            cur_ptr      <= q_done_rd_data.id;
            frame_buf_id <= q_done_rd_data.ctxt.buf_id;
            frame_len    <= q_done_rd_data.ctxt.offset_end;
        end else if (q_expired_rd) begin
            cur_ptr <= q_expired_rd_data;
        end
    end

    assign reap_if.ctxt           = state_pkg::UPDATE_CTXT_REAP;
    assign reap_if.id             = cur_ptr;
    assign reap_if.update         = '0;
    assign frag_ptr_dealloc_value = cur_ptr;

endmodule : sar_reassembly_state

// File: rtl/sar_reassembly_top.sv
`timescale 1ns/1ps

module sar_reassembly_top #(
    parameter int QUEUE_DEPTH = 8,
    parameter int EXPIRE_MS   = 4,
    parameter int SCAN_PERIOD = 2
) (
    input  logic               clk,
    input  logic               srst,
    output logic               init_done,
    input  logic               frag_valid,
    input  logic               frag_init,
    input  sar_pkg::frag_ptr_t frag_ptr,
    input  sar_pkg::buf_id_t   frag_buf_id,
    input  sar_pkg::offset_t   frag_offset_start,
    input  sar_pkg::offset_t   frag_offset_end,
    input  logic               frag_last,
    input  logic               frag_merged,
    input  sar_pkg::frag_ptr_t frag_merged_ptr,
    input  logic               ms_tick,
    input  logic               frame_ready,
    output logic               frame_valid,
    output sar_pkg::buf_id_t   frame_buf_id,
    output sar_pkg::offset_t   frame_len,
    input  logic               frag_ptr_dealloc_rdy,
    output logic               frag_ptr_dealloc_req,
    output sar_pkg::frag_ptr_t frag_ptr_dealloc_value
);

    state_pkg::timer_t      timer;
    logic                   scan_rd;
    sar_pkg::frag_ptr_t     scan_addr;
    state_pkg::frag_state_t scan_data;

    state_update_intf upd_if ();
    state_update_intf reap_if ();
    state_event_intf  done_evt_if ();
    state_event_intf  expired_evt_if ();

    sar_reassembly_state #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .EXPIRE_MS   (EXPIRE_MS),
        .SCAN_PERIOD (SCAN_PERIOD)
    ) i_sar_reassembly_state (
        .clk, .srst, .init_done,
        .frag_valid, .frag_init, .frag_ptr, .frag_buf_id,
        .frag_offset_start, .frag_offset_end, .frag_last,
        .frag_merged, .frag_merged_ptr, .ms_tick,
        .frame_ready, .frame_valid, .frame_buf_id, .frame_len,
        .frag_ptr_dealloc_rdy, .frag_ptr_dealloc_req, .frag_ptr_dealloc_value,
        .upd_if, .reap_if, .done_evt_if, .expired_evt_if, .timer
    );

    frag_state_store i_frag_state_store (
        .clk, .srst, .init_done,
        .upd_if, .reap_if, .done_evt_if, .expired_evt_if,
        .scan_rd, .scan_addr, .scan_data
    );

    frag_expiry_scan #(
        .EXPIRE_MS   (EXPIRE_MS),
        .SCAN_PERIOD (SCAN_PERIOD)
    ) i_frag_expiry_scan (
        .clk, .srst, .timer,
        .scan_rd, .scan_addr, .scan_data,
        .expired_evt_if
    );

endmodule : sar_reassembly_top

// File: tests/tb_sar_reassembly.sv
`timescale 1ns/1ps

module tb_sar_reassembly;

    localparam int QUEUE_DEPTH = 8;
    localparam int EXPIRE_MS   = 4;
    localparam int SCAN_PERIOD = 2;
    localparam int NUM_FRAGS   = sar_pkg::NUM_FRAGS;

    localparam int OP_UPD   = 0;
    localparam int OP_MERGE = 1;
    localparam int OP_TICK  = 2;
    localparam int OP_PAIR  = 3;

    localparam int NUM_ROWS    = 11;
    localparam int ROW_MAX_CYC = 200;
    localparam int SETTLE_CYC  = 8;
    // Ticks, one sweep for the stamp to age and one more to be read
    localparam int EXPIRY_CYC  = EXPIRE_MS * 2 + 2 * NUM_FRAGS * SCAN_PERIOD;
    localparam int TIMEOUT_NS  = (NUM_ROWS * ROW_MAX_CYC + EXPIRY_CYC + 100) * 4;

    typedef struct {
        int op;
        int ptr;
        int mptr;
        int buf_id;
        int ostart;
        int oend;
        int last;
        int init;
        int max_stall;
        int exp_frame;
        int exp_buf;
        int exp_len;
        int exp_ndealloc;
        int exp_ptr;
        int exp_ptr2;
    } row_t;

    logic               clk;
    logic               srst;
    logic               init_done;
    logic               frag_valid;
    logic               frag_init;
    sar_pkg::frag_ptr_t frag_ptr;
    sar_pkg::buf_id_t   frag_buf_id;
    sar_pkg::offset_t   frag_offset_start;
    sar_pkg::offset_t   frag_offset_end;
    logic               frag_last;
    logic               frag_merged;
    sar_pkg::frag_ptr_t frag_merged_ptr;
    logic               ms_tick;
    logic               frame_ready;
    logic               frame_valid;
    sar_pkg::buf_id_t   frame_buf_id;
    sar_pkg::offset_t   frame_len;
    logic               frag_ptr_dealloc_rdy;
    logic               frag_ptr_dealloc_req;
    sar_pkg::frag_ptr_t frag_ptr_dealloc_value;

    row_t        table_rows [NUM_ROWS];
    int          exp_buf_q[$];
    int          exp_len_q[$];
    int          exp_ptr_q[$];
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic [31:0] seed;
    int          f_left;
    int          d_left;

    logic               prev_fv;
    logic               prev_fr;
    sar_pkg::buf_id_t   prev_buf;
    sar_pkg::offset_t   prev_len;
    logic               prev_dv;
    logic               prev_dr;
    sar_pkg::frag_ptr_t prev_ptr;

    sar_reassembly_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .EXPIRE_MS   (EXPIRE_MS),
        .SCAN_PERIOD (SCAN_PERIOD)
    ) i_sar_reassembly_top (
        .clk, .srst, .init_done,
        .frag_valid, .frag_init, .frag_ptr, .frag_buf_id,
        .frag_offset_start, .frag_offset_end, .frag_last,
        .frag_merged, .frag_merged_ptr, .ms_tick,
        .frame_ready, .frame_valid, .frame_buf_id, .frame_len,
        .frag_ptr_dealloc_rdy, .frag_ptr_dealloc_req, .frag_ptr_dealloc_value
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
                                 input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic wait_row_end();
        int idle;
        idle = 0;
        while (idle < SETTLE_CYC) begin
            @(negedge clk);
            if (exp_buf_q.size() == 0 && exp_ptr_q.size() == 0 &&
                !frame_valid && !frag_ptr_dealloc_req) begin
                idle++;
            end else begin
                idle = 0;
            end
        end
    endtask

    task automatic drive_update(input row_t r);
        @(negedge clk);
        frag_valid        = 1'b1;
        frag_init         = r.init[0];
        frag_ptr          = r.ptr[3:0];
        frag_buf_id       = r.buf_id[5:0];
        frag_offset_start = r.ostart[13:0];
        frag_offset_end   = r.oend[13:0];
        frag_last         = r.last[0];
        @(negedge clk);
        frag_valid = 1'b0;
    endtask

    task automatic drive_merge(input int ptr);
        @(negedge clk);
        frag_merged     = 1'b1;
        frag_merged_ptr = ptr[3:0];
        @(negedge clk);
        frag_merged = 1'b0;
    endtask

    task automatic drive_ticks(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            ms_tick = 1'b1;
            @(negedge clk);
            ms_tick = 1'b0;
        end
    endtask

    // --------------------
    // Ready back-pressure
    // --------------------
    always @(negedge clk) begin
        if (frame_valid && f_left > 0) begin
            frame_ready = 1'b0;
            f_left--;
        end else begin
            frame_ready = 1'b1;
        end
        if (frag_ptr_dealloc_req && d_left > 0) begin
            frag_ptr_dealloc_rdy = 1'b0;
            d_left--;
        end else begin
            frag_ptr_dealloc_rdy = 1'b1;
        end
    end

    // --------------------
    // Output scoreboard
    // --------------------
    always @(posedge clk) begin
        if (!srst) begin
            if (prev_fv && !prev_fr) begin
                compare_value(frame_valid, 1'b1, "frame_valid held");
                compare_value(frame_buf_id, prev_buf, "frame_buf_id held");
                compare_value(frame_len, prev_len, "frame_len held");
            end
            if (prev_dv && !prev_dr) begin
                compare_value(frag_ptr_dealloc_req, 1'b1, "dealloc_req held");
                compare_value(frag_ptr_dealloc_value, prev_ptr, "dealloc_value held");
            end
            if (frame_valid && frame_ready) begin
                if (exp_buf_q.size() == 0) begin
                    $display("%0t ns: a frame came out that was not expected", $time);
                    errors++;
                end else begin
                    compare_value(frame_buf_id, exp_buf_q.pop_front(), "frame_buf_id");
                    compare_value(frame_len, exp_len_q.pop_front(), "frame_len");
                end
            end
            if (frag_ptr_dealloc_req && frag_ptr_dealloc_rdy) begin
                if (exp_ptr_q.size() == 0) begin
                    $display("%0t ns: a pointer was deallocated that was not expected", $time);
                    errors++;
                end else begin
                    compare_value(frag_ptr_dealloc_value, exp_ptr_q.pop_front(),
                                  "dealloc pointer");
                end
            end
        end
        prev_fv  = frame_valid;
        prev_fr  = frame_ready;
        prev_buf = frame_buf_id;
        prev_len = frame_len;
        prev_dv  = frag_ptr_dealloc_req;
        prev_dr  = frag_ptr_dealloc_rdy;
        prev_ptr = frag_ptr_dealloc_value;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the testbench stopped waiting for the DUT at %0t ns", $time);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int   cnt;
        int   err_before;
        row_t r;

        clk                  = 1'b0;
        srst                 = 1'b1;
        frag_valid           = 1'b0;
        frag_init            = 1'b0;
        frag_ptr             = '0;
        frag_buf_id          = '0;
        frag_offset_start    = '0;
        frag_offset_end      = '0;
        frag_last            = 1'b0;
        frag_merged          = 1'b0;
        frag_merged_ptr      = '0;
        ms_tick              = 1'b0;
        frame_ready          = 1'b1;
        frag_ptr_dealloc_rdy = 1'b1;
        f_left               = 0;
        d_left               = 0;
        errors               = 0;
        tests_run            = 0;
        tests_failed         = 0;
        seed                 = 32'h6ec8_ebec;

        //               op        ptr mptr buf start end   last init stall
        //               frame buf len    ndealloc ptr ptr2
        table_rows[0]  = '{OP_UPD,   3,  0,  5,  0,   100,   1, 1, 0, 1, 5,  100,   1, 3,  0};
        table_rows[1]  = '{OP_UPD,   7,  0,  9,  0,   64,    0, 1, 0, 0, 0,  0,     0, 0,  0};
        table_rows[2]  = '{OP_MERGE, 7,  0,  0,  0,   0,     0, 0, 2, 0, 0,  0,     1, 7,  0};
        table_rows[3]  = '{OP_UPD,   2,  0,  12, 40,  90,    1, 1, 0, 0, 0,  0,     0, 0,  0};
        table_rows[4]  = '{OP_MERGE, 2,  0,  0,  0,   0,     0, 0, 3, 0, 0,  0,     1, 2,  0};
        table_rows[5]  = '{OP_UPD,   9,  0,  33, 0,   1500,  1, 1, 7, 1, 33, 1500,  1, 9,  0};
        table_rows[6]  = '{OP_UPD,   15, 0,  63, 0,   16383, 1, 1, 7, 1, 63, 16383, 1, 15, 0};
        table_rows[7]  = '{OP_UPD,   4,  0,  20, 128, 256,   0, 1, 0, 0, 0,  0,     0, 0,  0};
        table_rows[8]  = '{OP_TICK,  4,  0,  0,  0,   0,     0, 0, 4, 0, 0,  0,     1, 4,  0};
        table_rows[9]  = '{OP_PAIR,  11, 6,  40, 0,   700,   1, 1, 3, 1, 40, 700,   2, 6,  11};
        table_rows[10] = '{OP_UPD,   0,  0,  1,  0,   1,     1, 1, 5, 1, 1,  1,     1, 0,  0};

        // --------------------
        // Reset and clear sweep
        // --------------------
        repeat (4) begin
            @(negedge clk);
            compare_value(frame_valid, 1'b0, "frame_valid in reset");
            compare_value(frag_ptr_dealloc_req, 1'b0, "dealloc_req in reset");
        end
        srst = 1'b0;
        cnt  = 0;
        while (!init_done && cnt < 40) begin
            @(negedge clk);
            cnt++;
            if (!init_done) begin
                compare_value(frame_valid, 1'b0, "frame_valid before init_done");
                compare_value(frag_ptr_dealloc_req, 1'b0, "dealloc_req before init_done");
            end
        end
        compare_value(cnt, NUM_FRAGS + 1, "cycles until init_done");
        tests_run++;
        if (errors != 0) begin
            tests_failed++;
        end
        $display("test init: %s", (errors == 0) ? "ok" : "errors");

        // --------------------
        // Table rows
        // --------------------
        for (int i = 0; i < NUM_ROWS; i++) begin
            r          = table_rows[i];
            err_before = errors;
            seed       = lcg_next(seed);
            f_left     = (seed >> 16) % (r.max_stall + 1);
            seed       = lcg_next(seed);
            d_left     = (seed >> 16) % (r.max_stall + 1);
            if (r.exp_frame != 0) begin
                exp_buf_q.push_back(r.exp_buf);
                exp_len_q.push_back(r.exp_len);
            end
            if (r.exp_ndealloc > 0) begin
                exp_ptr_q.push_back(r.exp_ptr);
            end
            if (r.exp_ndealloc > 1) begin
                exp_ptr_q.push_back(r.exp_ptr2);
            end
            case (r.op)
                OP_UPD:   drive_update(r);
                OP_MERGE: drive_merge(r.ptr);
                OP_TICK:  drive_ticks(EXPIRE_MS);
                OP_PAIR: begin
                    // Done event and merge reach their queues in the same cycle
                    fork
                        drive_update(r);
                        begin
                            @(negedge clk);
                            drive_merge(r.mptr);
                        end
                    join
                end
                default: ;
            endcase
            wait_row_end();
            tests_run++;
            if (errors != err_before) begin
                tests_failed++;
            end
            $display("test row %0d op %0d: %s", i, r.op, (errors == err_before) ? "ok" : "errors");
        end

        $display("tests run %0d, failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_sar_reassembly

// File: compile.f
rtl/sar_pkg.sv
rtl/state_pkg.sv
rtl/state_update_intf.sv
rtl/state_event_intf.sv
rtl/fifo_small.sv
rtl/frag_state_store.sv
rtl/frag_expiry_scan.sv
rtl/sar_reassembly_state.sv
rtl/sar_reassembly_top.sv
tests/tb_sar_reassembly.sv

// File: Bender.yml
package:
  name: sar_reassembly

sources:
  - rtl/sar_pkg.sv
  - rtl/state_pkg.sv
  - rtl/state_update_intf.sv
  - rtl/state_event_intf.sv
  - rtl/fifo_small.sv
  - rtl/frag_state_store.sv
  - rtl/frag_expiry_scan.sv
  - rtl/sar_reassembly_state.sv
  - rtl/sar_reassembly_top.sv
  - target: test
    files:
      - tests/tb_sar_reassembly.sv
